// File: verilog.f
design/ex_pkg.sv
design/ex_forward.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_lane.sv
design/ex_result_merge.sv
design/ex_stage.sv
tests/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_ex_stage -o sim_ex_stage
./obj_dir/sim_ex_stage > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: tests/tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage;

    import ex_pkg::*;

    localparam int NSRC       = BYPASS_SRCS_DEF;
    localparam int NUM_CYCLES = 5000;

    logic               aclk;
    logic               aresetn;
    issue_slot_t        slot0;
    issue_slot_t        slot1;
    bypass_t [NSRC-1:0] bypass;
    logic               hold;
    ex_out_t            result;
    logic               fwd_stall;
    ex_out_t            exp_next;
    ex_out_t            exp_out;
    logic               exp_stall;
    logic               captured;
    int                 error_count = 0;
    int                 timeout_count;
    int                 timeout;

    ex_stage #(.BYPASS_SRCS(NSRC)) ex_stage_inst (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .slot0_i         (slot0),
        .slot1_i         (slot1),
        .bypass_i        (bypass),
        .hold_i          (hold),
        .result_o        (result),
        .forward_stall_o (fwd_stall)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // corner values make equal and signed compares likely
    function automatic logic [31:0] pick_value();
        case ($urandom_range(0, 4))
            0: return 32'd0;
            1: return 32'd1;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    function automatic issue_slot_t random_slot();
        issue_slot_t s;
        s.valid       = ($urandom_range(0, 7) != 0);
        s.pc          = $urandom() & 32'hffff_fffc;
        // few registers, so bypass hits are common
        s.rj          = 5'($urandom_range(0, 3));
        s.rk          = 5'($urandom_range(0, 3));
        s.rd          = 5'($urandom_range(0, 7));
        s.rj_data     = pick_value();
        s.rk_data     = pick_value();
        s.imm         = ($urandom_range(0, 1) != 0) ? 32'($urandom_range(0, 40)) : pick_value();
        s.alu_op      = alu_op_e'(4'($urandom_range(0, 10)));
        s.src1_sel    = src1_sel_e'(1'($urandom_range(0, 1)));
        s.src2_sel    = src2_sel_e'(1'($urandom_range(0, 1)));
        s.br_cond     = ($urandom_range(0, 1) != 0) ? BR_NONE :
                        br_cond_e'(4'($urandom_range(1, 8)));
        s.pred_taken  = (s.br_cond == BR_NONE) ? ($urandom_range(0, 7) == 0) :
                        1'($urandom_range(0, 1));
        // jirl guesses from the register file value, right whenever nothing is forwarded
        s.pred_target = ($urandom_range(0, 1) != 0) ?
                        (((s.br_cond == BR_JIRL) ? s.rj_data : s.pc) + s.imm) : $urandom();
        return s;
    endfunction

    function automatic bypass_t random_bypass();
        bypass_t b;
        b.valid = ($urandom_range(0, 3) != 0);
        b.ready = ($urandom_range(0, 7) != 0);
        b.rd    = 5'($urandom_range(0, 3));
        b.data  = pick_value();
        return b;
    endfunction

    // bit 32 set means the winning producer is not ready
    function automatic logic [32:0] forward_operand(input logic [4:0] r, input logic [31:0] rf,
                                                    input bypass_t [NSRC-1:0] byp);
        for (int i = 0; i < NSRC; i++) begin
            if ((r != 5'd0) && byp[i].valid && (byp[i].rd == r)) begin
                return {!byp[i].ready, byp[i].data};
            end
        end
        return {1'b0, rf};
    endfunction

    function automatic lane_result_t model_lane(input issue_slot_t s,
                                                input bypass_t [NSRC-1:0] byp,
                                                output logic stall);
        logic [32:0]  fj;
        logic [32:0]  fk;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  y;
        logic [31:0]  tgt;
        logic         cond;
        lane_result_t r;
        fj    = forward_operand(s.rj, s.rj_data, byp);
        fk    = forward_operand(s.rk, s.rk_data, byp);
        stall = s.valid && (fj[32] || fk[32]);
        a     = (s.src1_sel == SRC1_PC) ? s.pc : fj[31:0];
        b     = (s.src2_sel == SRC2_IMM) ? s.imm : fk[31:0];
        case (s.alu_op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_SLL:    y = a << b[4:0];
            ALU_SRL:    y = a >> b[4:0];
            ALU_SRA:    y = (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}});
            ALU_SLT:    y = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU:   y = {31'd0, a < b};
            ALU_PASS_B: y = b;
            default:    y = 32'd0;
        endcase
        // signed compare by flipping the sign bits
        case (s.br_cond)
            BR_BEQ:  cond = (fj[31:0] == fk[31:0]);
            BR_BNE:  cond = (fj[31:0] != fk[31:0]);
            BR_BLT:  cond = ((fj[31:0] ^ 32'h8000_0000) < (fk[31:0] ^ 32'h8000_0000));
            BR_BGE:  cond = !((fj[31:0] ^ 32'h8000_0000) < (fk[31:0] ^ 32'h8000_0000));
            BR_BLTU: cond = (fj[31:0] < fk[31:0]);
            BR_BGEU: cond = !(fj[31:0] < fk[31:0]);
            BR_B:    cond = 1'b1;
            BR_JIRL: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        tgt           = (s.br_cond == BR_JIRL) ? (fj[31:0] + s.imm) : (s.pc + s.imm);
        r.valid       = s.valid;
        r.rd          = ((s.br_cond == BR_NONE) || (s.br_cond == BR_JIRL)) ? s.rd : 5'd0;
        r.data        = (s.br_cond == BR_JIRL) ? (s.pc + 32'd4) : y;
        r.taken       = s.valid && cond;
        r.target      = tgt;
        r.redirect_pc = cond ? tgt : (s.pc + 32'd4);
        r.mispredict  = s.valid && ((cond != s.pred_taken) || (cond && (tgt != s.pred_target)));
        return r;
    endfunction

    function automatic ex_out_t model_stage(input issue_slot_t s0, input issue_slot_t s1,
                                            input bypass_t [NSRC-1:0] byp, output logic stall);
        logic    st0;
        logic    st1;
        ex_out_t o;
        o.lane0 = model_lane(s0, byp, st0);
        o.lane1 = model_lane(s1, byp, st1);
        if (o.lane0.taken) begin
            o.lane1 = '0;
        end
        o.redirect_valid = o.lane0.mispredict || o.lane1.mispredict;
        o.redirect_pc    = o.lane0.mispredict ? o.lane0.redirect_pc :
                           (o.lane1.mispredict ? o.lane1.redirect_pc : 32'd0);
        stall = st0 || st1;
        return stall ? '0 : o;
    endfunction

    always_comb begin
        exp_next = model_stage(slot0, slot1, bypass, exp_stall);
    end

    // expected output register, one cycle behind the inputs
    always @(posedge aclk) begin
        if (!aresetn) begin
            exp_out  <= '0;
            captured <= 1'b0;
        end else if (!hold) begin
            exp_out  <= exp_next;
            captured <= 1'b1;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        !captured |-> !(result.lane0.valid || result.lane1.valid || result.redirect_valid))
        else begin
            error_count++;
            $display("Error: result_o valid bits expected 0 got %h",
                     {$sampled(result.lane0.valid), $sampled(result.lane1.valid),
                      $sampled(result.redirect_valid)});
        end

    assert property (@(posedge aclk) disable iff (!aresetn) fwd_stall == exp_stall)
        else begin
            error_count++;
            $display("Error: forward_stall_o expected %h got %h", $sampled(exp_stall),
                     $sampled(fwd_stall));
        end

    assert property (@(posedge aclk) disable iff (!aresetn) result.lane0 == exp_out.lane0)
        else begin
            error_count++;
            $display("Error: result_o.lane0 expected %h got %h", $sampled(exp_out.lane0),
                     $sampled(result.lane0));
        end

    assert property (@(posedge aclk) disable iff (!aresetn) result.lane1 == exp_out.lane1)
        else begin
            error_count++;
            $display("Error: result_o.lane1 expected %h got %h", $sampled(exp_out.lane1),
                     $sampled(result.lane1));
        end

    assert property (@(posedge aclk) disable iff (!aresetn)
        {result.redirect_valid, result.redirect_pc} ==
            {exp_out.redirect_valid, exp_out.redirect_pc})
        else begin
            error_count++;
            $display("Error: result_o.redirect expected %h got %h",
                     $sampled({exp_out.redirect_valid, exp_out.redirect_pc}),
                     $sampled({result.redirect_valid, result.redirect_pc}));
        end

    assert property (@(posedge aclk) disable iff (!aresetn)
        (result.lane0.valid && result.lane0.taken) |-> !result.lane1.valid)
        else begin
            error_count++;
            $display("Error: result_o.lane1.valid expected 0 got 1 behind a taken lane 0");
        end

    assert property (@(posedge aclk) disable iff (!aresetn) hold |=> $stable(result))
        else begin
            error_count++;
            $display("Error: result_o under hold_i expected %h got %h", $past(result),
                     $sampled(result));
        end

    initial begin
        void'($urandom(9609));
        timeout_count = 0;
        aresetn = 1'b0;
        // hold starts high so valid slots wait through reset
        hold    = 1'b1;
        slot0   = random_slot();
        slot1   = random_slot();
        for (int i = 0; i < NSRC; i++) begin
            bypass[i] = random_bypass();
        end
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (4) @(posedge aclk);
        hold <= 1'b0;
        timeout = 0;
        while (!captured && (timeout < 10)) begin
            @(negedge aclk);
            timeout++;
        end
        if (!captured) begin
            timeout_count++;
            $display("timeout while waiting for the first capture after reset");
        end
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge aclk);
            // a held item stays at the inputs
            if (!hold) begin
                slot0 <= random_slot();
                slot1 <= random_slot();
                for (int i = 0; i < NSRC; i++) begin
                    bypass[i] <= random_bypass();
                end
            end
            hold <= ($urandom_range(0, 4) == 0);
        end
        // drain with empty slots
        @(posedge aclk);
        hold  <= 1'b0;
        slot0 <= '0;
        slot1 <= '0;
        timeout = 0;
        do begin
            @(negedge aclk);
            timeout++;
        end while ((result.lane0.valid || result.lane1.valid) && (timeout < 20));
        if (result.lane0.valid || result.lane1.valid) begin
            timeout_count++;
            $display("timeout while waiting for the output to drain");
        end
        $display("cycles: %0d, errors: %0d, timeouts: %0d", NUM_CYCLES, error_count,
                 timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/10ps

module ex_stage #(
    parameter int BYPASS_SRCS = ex_pkg::BYPASS_SRCS_DEF
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  ex_pkg::issue_slot_t              slot0_i,
    input  ex_pkg::issue_slot_t              slot1_i,
    input  ex_pkg::bypass_t [BYPASS_SRCS-1:0] bypass_i,
    input  logic                             hold_i,
    output ex_pkg::ex_out_t                  result_o,
    output logic                             forward_stall_o
);

    import ex_pkg::*;

    lane_result_t lane0_res;
    lane_result_t lane1_res;
    logic         lane0_stall;
    logic         lane1_stall;

    // both lanes see the same bypass sources
    ex_lane #(.BYPASS_SRCS(BYPASS_SRCS)) lane0_inst (
        .slot_i   (slot0_i),
        .bypass_i (bypass_i),
        .result_o (lane0_res),
        .stall_o  (lane0_stall)
    );

    ex_lane #(.BYPASS_SRCS(BYPASS_SRCS)) lane1_inst (
        .slot_i   (slot1_i),
        .bypass_i (bypass_i),
        .result_o (lane1_res),
        .stall_o  (lane1_stall)
    );

    ex_result_merge merge_inst (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .lane0_i         (lane0_res),
        .lane1_i         (lane1_res),
        .stall0_i        (lane0_stall),
        .stall1_i        (lane1_stall),
        .hold_i          (hold_i),
        .result_o        (result_o),
        .forward_stall_o (forward_stall_o)
    );

endmodule

// File: design/ex_result_merge.sv
`timescale 1ns/10ps

module ex_result_merge (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  ex_pkg::lane_result_t lane0_i,
    input  ex_pkg::lane_result_t lane1_i,
    input  logic                 stall0_i,
    input  logic                 stall1_i,
    input  logic                 hold_i,
    output ex_pkg::ex_out_t      result_o,
    output logic                 forward_stall_o
);

    import ex_pkg::*;

    lane_result_t lane1_kept;
    ex_out_t      next_out;
    logic         lane0_jumps;

    assign forward_stall_o = stall0_i | stall1_i;

    assign lane0_jumps = lane0_i.valid && lane0_i.taken;

    // younger lane is on the wrong path once lane 0 jumps
    always_comb begin
        if (lane0_jumps) begin
            lane1_kept = '0;
        end else begin
            lane1_kept = lane1_i;
        end
    end

    always_comb begin
        next_out.lane0          = lane0_i;
        next_out.lane1          = lane1_kept;
        next_out.redirect_valid = 1'b0;
        next_out.redirect_pc    = 32'd0;
        // older lane wins the redirect
        if (lane0_i.valid && lane0_i.mispredict) begin
            next_out.redirect_valid = 1'b1;
            next_out.redirect_pc    = lane0_i.redirect_pc;
        end else if (lane1_kept.valid && lane1_kept.mispredict) begin
            next_out.redirect_valid = 1'b1;
            next_out.redirect_pc    = lane1_kept.redirect_pc;
        end
        // send a bubble while an operand is not ready
        if (forward_stall_o) begin
            next_out = '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            result_o <= '0;
        end else if (!hold_i) begin
            result_o <= next_out;
        end
    end

    // a redirect needs a registered lane that actually mispredicted
    assert property (@(posedge aclk) disable iff (!aresetn)
        result_o.redirect_valid |->
            ((result_o.lane0.valid && result_o.lane0.mispredict) ||
             (result_o.lane1.valid && result_o.lane1.mispredict)))
        else $error("ex_result_merge: redirect without a mispredicted lane");

    // squash must reach the register
    assert property (@(posedge aclk) disable iff (!aresetn)
        (result_o.lane0.valid && result_o.lane0.taken) |-> !result_o.lane1.valid)
        else $error("ex_result_merge: lane 1 survived a taken lane 0 branch");

endmodule

// File: design/ex_lane.sv
`timescale 1ns/10ps

module ex_lane #(
    parameter int BYPASS_SRCS = ex_pkg::BYPASS_SRCS_DEF
) (
    input  ex_pkg::issue_slot_t              slot_i,
    input  ex_pkg::bypass_t [BYPASS_SRCS-1:0] bypass_i,
    output ex_pkg::lane_result_t             result_o,
    output logic                             stall_o
);

    import ex_pkg::*;

    logic [31:0] rj_val;
    logic [31:0] rk_val;
    logic        rj_hit;
    logic        rk_hit;
    logic        rj_stall;
    logic        rk_stall;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] br_redirect;
    logic        br_mispredict;
    logic        is_branch;
    logic        is_jirl;
    logic [31:0] link_pc;

    ex_forward #(.BYPASS_SRCS(BYPASS_SRCS)) fwd_rj_inst (
        .reg_i     (slot_i.rj),
        .rf_data_i (slot_i.rj_data),
        .bypass_i  (bypass_i),
        .data_o    (rj_val),
        .hit_o     (rj_hit),
        .stall_o   (rj_stall)
    );

    ex_forward #(.BYPASS_SRCS(BYPASS_SRCS)) fwd_rk_inst (
        .reg_i     (slot_i.rk),
        .rf_data_i (slot_i.rk_data),
        .bypass_i  (bypass_i),
        .data_o    (rk_val),
        .hit_o     (rk_hit),
        .stall_o   (rk_stall)
    );

    // operand muxes
    assign alu_a = (slot_i.src1_sel == SRC1_PC) ? slot_i.pc : rj_val;
    assign alu_b = (slot_i.src2_sel == SRC2_IMM) ? slot_i.imm : rk_val;

    ex_alu alu_inst (
        .op_i (slot_i.alu_op),
        .a_i  (alu_a),
        .b_i  (alu_b),
        .y_o  (alu_y)
    );

    ex_branch branch_inst (
        .cond_i        (slot_i.br_cond),
        .pc_i          (slot_i.pc),
        .rj_i          (rj_val),
        .rk_i          (rk_val),
        .imm_i         (slot_i.imm),
        .pred_taken_i  (slot_i.pred_taken),
        .pred_target_i (slot_i.pred_target),
        .taken_o       (br_taken),
        .target_o      (br_target),
        .redirect_pc_o (br_redirect),
        .mispredict_o  (br_mispredict)
    );

    assign is_branch = (slot_i.br_cond != BR_NONE);
    assign is_jirl   = (slot_i.br_cond == BR_JIRL);
    assign link_pc   = slot_i.pc + 32'd4;

    // an empty slot neither stalls nor redirects
    assign stall_o = slot_i.valid && ((rj_hit && rj_stall) || (rk_hit && rk_stall));

    always_comb begin
        result_o.valid       = slot_i.valid;
        // plain branches do not write back
        result_o.rd          = (is_branch && !is_jirl) ? 5'd0 : slot_i.rd;
        result_o.data        = is_jirl ? link_pc : alu_y;
        result_o.taken       = slot_i.valid && br_taken;
        result_o.target      = br_target;
        result_o.redirect_pc = br_redirect;
        result_o.mispredict  = slot_i.valid && br_mispredict;
    end

endmodule

// File: design/ex_branch.sv
`timescale 1ns/10ps

module ex_branch (
    input  ex_pkg::br_cond_e cond_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      rj_i,
    input  logic [31:0]      rk_i,
    input  logic [31:0]      imm_i,
    input  logic             pred_taken_i,
    input  logic [31:0]      pred_target_i,
    output logic             taken_o,
    output logic [31:0]      target_o,
    output logic [31:0]      redirect_pc_o,
    output logic             mispredict_o
);

    import ex_pkg::*;

    logic [31:0] seq_pc;
    logic        cond_met;

    // compare on the forwarded operands
    always_comb begin
        case (cond_i)
            BR_BEQ:  cond_met = (rj_i == rk_i);
            BR_BNE:  cond_met = (rj_i != rk_i);
            BR_BLT:  cond_met = ($signed(rj_i) < $signed(rk_i));
            BR_BGE:  cond_met = ($signed(rj_i) >= $signed(rk_i));
            BR_BLTU: cond_met = (rj_i < rk_i);
            BR_BGEU: cond_met = (rj_i >= rk_i);
            BR_B:    cond_met = 1'b1;
            BR_JIRL: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    assign seq_pc = pc_i + 32'd4;

    // jirl is the only register relative target
    assign target_o = (cond_i == BR_JIRL) ? (rj_i + imm_i) : (pc_i + imm_i);

    assign taken_o = cond_met;

    assign redirect_pc_o = taken_o ? target_o : seq_pc;

    // wrong direction, or right direction but wrong place
    assign mispredict_o = (taken_o != pred_taken_i) ||
                          (taken_o && (target_o != pred_target_i));

endmodule

// File: design/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
    input  ex_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     y_o
);

    import ex_pkg::*;

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                y_o = a_i + b_i;
            end
            ALU_SUB: begin
                y_o = a_i - b_i;
            end
            ALU_AND: begin
                y_o = a_i & b_i;
            end
            ALU_OR: begin
                y_o = a_i | b_i;
            end
            ALU_XOR: begin
                y_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                y_o = a_i << shamt;
            end
            ALU_SRL: begin
                y_o = a_i >> shamt;
            end
            ALU_SRA: begin
                y_o = $signed(a_i) >>> shamt;
            end
            ALU_SLT: begin
                y_o = {31'd0, $signed(a_i) < $signed(b_i)};
            end
            ALU_SLTU: begin
                y_o = {31'd0, a_i < b_i};
            end
            ALU_PASS_B: begin
                y_o = b_i;
            end
            default: begin
                y_o = 32'd0;
            end
        endcase
    end

endmodule

// File: design/ex_forward.sv
`timescale 1ns/10ps

module ex_forward #(
    parameter int BYPASS_SRCS = ex_pkg::BYPASS_SRCS_DEF
) (
    input  logic [4:0]                       reg_i,
    input  logic [31:0]                      rf_data_i,
    input  ex_pkg::bypass_t [BYPASS_SRCS-1:0] bypass_i,
    output logic [31:0]                      data_o,
    output logic                             hit_o,
    output logic                             stall_o
);

    // walk from oldest to youngest so the lowest index overwrites
    always_comb begin
        data_o  = rf_data_i;
        hit_o   = 1'b0;
        stall_o = 1'b0;
        for (int i = BYPASS_SRCS - 1; i >= 0; i--) begin
            // r0 is hardwired and never takes a bypass
            if (bypass_i[i].valid && (bypass_i[i].rd == reg_i) && (reg_i != 5'd0)) begin
                hit_o   = 1'b1;
                stall_o = !bypass_i[i].ready;
                data_o  = bypass_i[i].data;
            end
        end
    end

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

    // number of bypass sources, index 0 is the youngest producer
    parameter int BYPASS_SRCS_DEF = 3;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        // lu12i style, result is operand b
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        // pc relative, no link
        BR_B    = 4'd7,
        // register relative, links pc+4
        BR_JIRL = 4'd8
    } br_cond_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic {
        SRC2_REG = 1'b0,
        SRC2_IMM = 1'b1
    } src2_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic [31:0] rj_data;
        logic [31:0] rk_data;
        logic [31:0] imm;
        alu_op_e     alu_op;
        src1_sel_e   src1_sel;
        src2_sel_e   src2_sel;
        br_cond_e    br_cond;
        logic        pred_taken;
        logic [31:0] pred_target;
    } issue_slot_t;

    // ready low means the producer has not computed its value yet
    typedef struct packed {
        logic        valid;
        logic        ready;
        logic [4:0]  rd;
        logic [31:0] data;
    } bypass_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic [31:0] redirect_pc;
        logic        mispredict;
    } lane_result_t;

    typedef struct packed {
        lane_result_t lane0;
        lane_result_t lane1;
        logic         redirect_valid;
        logic [31:0]  redirect_pc;
    } ex_out_t;

endpackage
